//--- src/noc_pkg.sv
package noc_pkg;

	localparam int NUM_PORTS = 5;

	typedef logic [2:0] port_t;

	localparam port_t PORT_N = 3'd0;
	localparam port_t PORT_S = 3'd1;
	localparam port_t PORT_W = 3'd2;
	localparam port_t PORT_E = 3'd3;
	localparam port_t PORT_L = 3'd4;

	// router address, Y in the upper half and X in the lower half
	localparam int ADDR_W = 8;
	localparam int COORD_W = ADDR_W / 2;

	localparam int DATA_W = 16;

	localparam int FIFO_DEPTH = 4;
	localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
	localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

	// a head flit carries the destination in its low ADDR_W data bits
	typedef struct packed {
		logic              head;
		logic              tail;
		logic [DATA_W-1:0] data;
	} flit_t;

	// what one input asks of the arbiters
	typedef struct packed {
		logic  valid;
		port_t port;
		logic  tail;
	} route_req_t;

endpackage

//--- src/flit_fifo.sv
`timescale 1ns/1ps

module flit_fifo (
	input  logic           clk,
	input  logic           rst_n_i,
	input  noc_pkg::flit_t wr_flit_i,
	input  logic           wr_valid_i,
	output logic           wr_ready_o,
	output noc_pkg::flit_t rd_flit_o,
	output logic           rd_valid_o,
	input  logic           rd_pop_i
);
	import noc_pkg::*;

	flit_t                 mem [FIFO_DEPTH];
	logic [FIFO_PTR_W-1:0] wr_ptr_q;
	logic [FIFO_PTR_W-1:0] rd_ptr_q;
	logic [FIFO_CNT_W-1:0] count_q;
	logic                  do_write;
	logic                  do_read;

	function automatic logic [FIFO_PTR_W-1:0] next_ptr(input logic [FIFO_PTR_W-1:0] ptr);
		if (ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) begin
			return '0;
		end
		return ptr + FIFO_PTR_W'(1);
	endfunction

	assign wr_ready_o = (count_q != FIFO_CNT_W'(FIFO_DEPTH));
	assign rd_valid_o = (count_q != '0);
	assign rd_flit_o  = mem[rd_ptr_q];
	assign do_write   = wr_valid_i && wr_ready_o;
	assign do_read    = rd_pop_i && rd_valid_o;

	always_ff @(posedge clk) begin
		if (do_write) begin
			mem[wr_ptr_q] <= wr_flit_i;
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			if (do_write) begin
				wr_ptr_q <= next_ptr(wr_ptr_q);
			end
			if (do_read) begin
				rd_ptr_q <= next_ptr(rd_ptr_q);
			end
			// a write and a pop in one cycle leave the count alone
			case ({do_write, do_read})
				2'b10:   count_q <= count_q + FIFO_CNT_W'(1);
				2'b01:   count_q <= count_q - FIFO_CNT_W'(1);
				default: count_q <= count_q;
			endcase
		end
	end

endmodule

//--- src/route_unit.sv
`timescale 1ns/1ps

module route_unit (
	input  logic                        clk,
	input  logic                        rst_n_i,
	input  logic [noc_pkg::ADDR_W-1:0]  router_addr_i,
	input  noc_pkg::flit_t              flit_i,
	input  logic                        flit_valid_i,
	input  logic                        pop_i,
	output noc_pkg::route_req_t         req_o
);
	import noc_pkg::*;

	logic [COORD_W-1:0] dst_y;
	logic [COORD_W-1:0] dst_x;
	logic [COORD_W-1:0] own_y;
	logic [COORD_W-1:0] own_x;
	port_t              yx_port;
	port_t              hop_q;
	port_t              cur_port;

	assign dst_y = flit_i.data[ADDR_W-1:COORD_W];
	assign dst_x = flit_i.data[COORD_W-1:0];
	assign own_y = router_addr_i[ADDR_W-1:COORD_W];
	assign own_x = router_addr_i[COORD_W-1:0];

	// Y is resolved first, X only once the row matches
	always_comb begin
		if (dst_y > own_y) begin
			yx_port = PORT_N;
		end else if (dst_y < own_y) begin
			yx_port = PORT_S;
		end else if (dst_x > own_x) begin
			yx_port = PORT_E;
		end else if (dst_x < own_x) begin
			yx_port = PORT_W;
		end else begin
			yx_port = PORT_L;
		end
	end

	// the head decides, body and tail flits follow the stored hop
	assign cur_port = flit_i.head ? yx_port : hop_q;

	// next-hop register, rewritten only when a head flit leaves the buffer
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			hop_q <= PORT_N;
		end else if (pop_i && flit_i.head) begin
			hop_q <= yx_port;
		end
	end

	always_comb begin
		req_o.valid = flit_valid_i;
		req_o.port  = cur_port;
		req_o.tail  = flit_i.tail;
	end

endmodule

//--- src/rr_arbiter.sv
`timescale 1ns/1ps

module rr_arbiter #(
	parameter noc_pkg::port_t OUT_PORT = noc_pkg::PORT_N
) (
	input  logic                          clk,
	input  logic                          rst_n_i,
	input  noc_pkg::route_req_t           req_i [noc_pkg::NUM_PORTS],
	input  logic                          out_ready_i,
	output logic [noc_pkg::NUM_PORTS-1:0] grant_o
);
	import noc_pkg::*;

	logic [NUM_PORTS-1:0] match;
	logic                 lock_q;
	port_t                gnt_idx_q;
	port_t                ptr_q;
	port_t                pick_idx;
	logic                 pick_found;
	port_t                cur_idx;
	logic                 active;
	logic                 xfer;

	function automatic port_t wrap_inc(input port_t idx);
		if (idx == port_t'(NUM_PORTS - 1)) begin
			return PORT_N;
		end
		return idx + 3'd1;
	endfunction

	always_comb begin
		for (int i = 0; i < NUM_PORTS; i++) begin
			match[i] = req_i[i].valid && (req_i[i].port == OUT_PORT);
		end
	end

	// first requester at or after the priority pointer
	always_comb begin
		port_t idx;
		idx        = ptr_q;
		pick_idx   = ptr_q;
		pick_found = 1'b0;
		for (int k = 0; k < NUM_PORTS; k++) begin
			if (!pick_found && match[idx]) begin
				pick_idx   = idx;
				pick_found = 1'b1;
			end
			idx = wrap_inc(idx);
		end
	end

	assign cur_idx = lock_q ? gnt_idx_q : pick_idx;
	assign active  = lock_q || pick_found;
	assign xfer    = active && match[cur_idx] && out_ready_i;

	always_comb begin
		grant_o = '0;
		if (active) begin
			grant_o[cur_idx] = 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			lock_q    <= 1'b0;
			gnt_idx_q <= PORT_N;
			ptr_q     <= PORT_N;
		end else if (xfer) begin
			if (req_i[cur_idx].tail) begin
				lock_q <= 1'b0;
				ptr_q  <= wrap_inc(cur_idx);
			end else begin
				lock_q    <= 1'b1;
				gnt_idx_q <= cur_idx;
			end
		end
	end

endmodule

//--- src/crossbar_switch.sv
`timescale 1ns/1ps

module crossbar_switch (
	input  noc_pkg::flit_t                fifo_flit_i [noc_pkg::NUM_PORTS],
	input  logic [noc_pkg::NUM_PORTS-1:0] fifo_valid_i,
	input  logic [noc_pkg::NUM_PORTS-1:0] grant_i [noc_pkg::NUM_PORTS],
	input  logic [noc_pkg::NUM_PORTS-1:0] out_ready_i,
	output noc_pkg::flit_t                out_flit_o [noc_pkg::NUM_PORTS],
	output logic [noc_pkg::NUM_PORTS-1:0] out_valid_o,
	output logic [noc_pkg::NUM_PORTS-1:0] fifo_pop_o
);
	import noc_pkg::*;

	// grant_i[o][i] means output o currently serves input i
	always_comb begin
		for (int o = 0; o < NUM_PORTS; o++) begin
			out_flit_o[o]  = '0;
			out_valid_o[o] = 1'b0;
			for (int i = 0; i < NUM_PORTS; i++) begin
				if (grant_i[o][i]) begin
					out_flit_o[o]  = fifo_flit_i[i];
					out_valid_o[o] = fifo_valid_i[i];
				end
			end
		end
	end

	// each input is granted by at most one output, since it names a single port
	always_comb begin
		fifo_pop_o = '0;
		for (int i = 0; i < NUM_PORTS; i++) begin
			for (int o = 0; o < NUM_PORTS; o++) begin
				fifo_pop_o[i] = fifo_pop_o[i] |
					(grant_i[o][i] & out_ready_i[o] & fifo_valid_i[i]);
			end
		end
	end

endmodule

//--- src/router_core.sv
`timescale 1ns/1ps

module router_core (
	input  logic                          clk,
	input  logic                          rst_n_i,
	input  logic [noc_pkg::ADDR_W-1:0]    router_addr_i,
	input  noc_pkg::flit_t                in_flit_i [noc_pkg::NUM_PORTS],
	input  logic [noc_pkg::NUM_PORTS-1:0] in_valid_i,
	output logic [noc_pkg::NUM_PORTS-1:0] in_ready_o,
	output noc_pkg::flit_t                out_flit_o [noc_pkg::NUM_PORTS],
	output logic [noc_pkg::NUM_PORTS-1:0] out_valid_o,
	input  logic [noc_pkg::NUM_PORTS-1:0] out_ready_i
);
	import noc_pkg::*;

	flit_t                fifo_flit [NUM_PORTS];
	logic [NUM_PORTS-1:0] fifo_valid;
	logic [NUM_PORTS-1:0] fifo_pop;
	route_req_t           req [NUM_PORTS];
	logic [NUM_PORTS-1:0] grant [NUM_PORTS];

	// input side, one buffer and one route unit per port
	for (genvar p = 0; p < NUM_PORTS; p++) begin : g_in
		flit_fifo u_fifo (
			.clk        (clk),
			.rst_n_i    (rst_n_i),
			.wr_flit_i  (in_flit_i[p]),
			.wr_valid_i (in_valid_i[p]),
			.wr_ready_o (in_ready_o[p]),
			.rd_flit_o  (fifo_flit[p]),
			.rd_valid_o (fifo_valid[p]),
			.rd_pop_i   (fifo_pop[p])
		);

		route_unit u_route (
			.clk           (clk),
			.rst_n_i       (rst_n_i),
			.router_addr_i (router_addr_i),
			.flit_i        (fifo_flit[p]),
			.flit_valid_i  (fifo_valid[p]),
			.pop_i         (fifo_pop[p]),
			.req_o         (req[p])
		);
	end

	// output side, one arbiter per port sees every request
	for (genvar p = 0; p < NUM_PORTS; p++) begin : g_out
		rr_arbiter #(
			.OUT_PORT (port_t'(p))
		) u_arb (
			.clk         (clk),
			.rst_n_i     (rst_n_i),
			.req_i       (req),
			.out_ready_i (out_ready_i[p]),
			.grant_o     (grant[p])
		);
	end

	crossbar_switch u_xbar (
		.fifo_flit_i  (fifo_flit),
		.fifo_valid_i (fifo_valid),
		.grant_i      (grant),
		.out_ready_i  (out_ready_i),
		.out_flit_o   (out_flit_o),
		.out_valid_o  (out_valid_o),
		.fifo_pop_o   (fifo_pop)
	);

endmodule

//--- sim/tb_router_core.sv
`timescale 1ns/1ps

module tb_router_core;
	import noc_pkg::*;

	localparam logic [ADDR_W-1:0] ROUTER_ADDR = 8'h22;
	localparam int MAX_PKTS       = 64;
	localparam int VEC_FIELDS     = 5;
	localparam int NUM_GROUPS     = 5;
	localparam int ROTATE_GROUP   = 4;
	localparam int JITTER_GROUP   = 5;
	localparam int TIMEOUT_CYCLES = 2000;

	logic                 clk;
	logic                 rst_n;
	logic [ADDR_W-1:0]    router_addr;
	flit_t                in_flit [NUM_PORTS];
	logic [NUM_PORTS-1:0] in_valid;
	logic [NUM_PORTS-1:0] in_ready;
	flit_t                out_flit [NUM_PORTS];
	logic [NUM_PORTS-1:0] out_valid;
	logic [NUM_PORTS-1:0] out_ready;

	logic [15:0] vec_mem [MAX_PKTS*VEC_FIELDS];
	int          vec_grp [MAX_PKTS];
	int          vec_in [MAX_PKTS];
	logic [7:0]  vec_dst [MAX_PKTS];
	int          vec_len [MAX_PKTS];
	logic [15:0] vec_pay [MAX_PKTS];
	int          num_pkts;

	// expected flits are indexed by output * NUM_PORTS + input
	flit_t       exp_q [NUM_PORTS*NUM_PORTS][$];
	port_t       route_q [NUM_PORTS];
	int          occ [NUM_PORTS];
	logic        busy [NUM_PORTS];
	int          cur_src [NUM_PORTS];
	int          last_src [NUM_PORTS];
	int          delivered;
	string       test_name;
	logic        jitter_on;
	logic        rot_check;
	logic        rot_first;
	int          seed;
	logic [31:0] rnd;

	router_core uut (
		.clk           (clk),
		.rst_n_i       (rst_n),
		.router_addr_i (router_addr),
		.in_flit_i     (in_flit),
		.in_valid_i    (in_valid),
		.in_ready_o    (in_ready),
		.out_flit_o    (out_flit),
		.out_valid_o   (out_valid),
		.out_ready_i   (out_ready)
	);

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("ERRORS FOUND");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task automatic flag_mismatch(input string what, input logic [31:0] expv,
			input logic [31:0] actv);
		abort_run($sformatf("Error %s, %s: expected %h, actual %h",
			test_name, what, expv, actv));
	endtask

	// YX rule against this router's own address
	function automatic port_t route_of(input logic [7:0] dst);
		if (dst[7:4] > ROUTER_ADDR[7:4])
			return PORT_N;
		if (dst[7:4] < ROUTER_ADDR[7:4])
			return PORT_S;
		if (dst[3:0] > ROUTER_ADDR[3:0])
			return PORT_E;
		if (dst[3:0] < ROUTER_ADDR[3:0])
			return PORT_W;
		return PORT_L;
	endfunction

	// the upper head byte tags the packet so the monitor knows its source
	function automatic flit_t make_flit(input int idx, input int f);
		flit_t fl;
		fl.head = (f == 0);
		fl.tail = (f == vec_len[idx] - 1);
		fl.data = (f == 0) ? {idx[7:0], vec_dst[idx]} : vec_pay[idx] + 16'(f);
		return fl;
	endfunction

	function automatic int next_waiting(input int o, input int last);
		int cand;
		for (int k = 1; k <= NUM_PORTS; k++) begin
			cand = (last + k) % NUM_PORTS;
			if (exp_q[o * NUM_PORTS + cand].size() != 0)
				return cand;
		end
		return -1;
	endfunction

	function automatic int pending_flits();
		int n;
		n = 0;
		for (int k = 0; k < NUM_PORTS * NUM_PORTS; k++)
			n += exp_q[k].size();
		return n;
	endfunction

	function automatic string group_name(input int grp);
		case (grp)
			1:       return "yx routing set 1";
			2:       return "yx routing set 2";
			3:       return "shared output east";
			4:       return "round robin on local";
			default: return "random back-pressure";
		endcase
	endfunction

	task automatic load_vectors();
		int k;
		$readmemh("sim/router_vectors.txt", vec_mem);
		num_pkts = 0;
		k = 0;
		while (num_pkts < MAX_PKTS && vec_mem[k] != 16'h00ff) begin
			vec_grp[num_pkts] = int'(vec_mem[k]);
			vec_in[num_pkts]  = int'(vec_mem[k+1]);
			vec_dst[num_pkts] = vec_mem[k+2][7:0];
			vec_len[num_pkts] = int'(vec_mem[k+3]);
			vec_pay[num_pkts] = vec_mem[k+4];
			num_pkts++;
			k += VEC_FIELDS;
		end
		assert (num_pkts > 0 && num_pkts < MAX_PKTS) else
			abort_run("the vector file is missing or has no end marker");
	endtask

	// each input has its own sender that starts just after a rising edge
	task automatic send_port(input int s, input int grp);
		int   waited;
		logic accepted;
		for (int i = 0; i < num_pkts; i++) begin
			if (vec_grp[i] == grp && vec_in[i] == s) begin
				for (int f = 0; f < vec_len[i]; f++) begin
					in_flit[s]  = make_flit(i, f);
					in_valid[s] = 1'b1;
					accepted    = 1'b0;
					waited      = 0;
					while (!accepted) begin
						@(negedge clk);
						accepted = in_ready[s];
						@(posedge clk);
						#1;
						waited++;
						assert (accepted || waited < TIMEOUT_CYCLES) else
							abort_run($sformatf("%s: input %0d was never ready",
								test_name, s));
					end
				end
			end
		end
		in_valid[s] = 1'b0;
	endtask

	task automatic drain_queues();
		int waited;
		waited = 0;
		while (pending_flits() != 0) begin
			@(posedge clk);
			waited++;
			assert (waited < TIMEOUT_CYCLES) else
				abort_run($sformatf("%s: a packet was never delivered", test_name));
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		seed      = 32'h7e99c80b;
		out_ready = '1;
		forever begin
			@(posedge clk);
			#1;
			rnd       = $random(seed);
			out_ready = jitter_on ? (rnd[4:0] & rnd[9:5]) : '1;
		end
	end

	// the monitor samples on the falling edge where inputs and outputs have settled
	always @(negedge clk) begin
		flit_t act;
		flit_t expf;
		int    src;
		int    key;
		int    want;
		if (rst_n) begin
			for (int s = 0; s < NUM_PORTS; s++) begin
				assert (in_ready[s] == (occ[s] != FIFO_DEPTH)) else
					flag_mismatch($sformatf("in_ready of input %0d", s),
						32'(occ[s] != FIFO_DEPTH), 32'(in_ready[s]));
			end
			// outputs go first so a head accepted this cycle is not yet waiting
			for (int o = 0; o < NUM_PORTS; o++) begin
				if (out_valid[o] && out_ready[o]) begin
					act = out_flit[o];
					if (!busy[o]) begin
						assert (act.head) else
							flag_mismatch($sformatf("head flag on output %0d", o),
								32'd1, 32'(act.head));
						assert (int'(act.data[15:8]) < num_pkts) else
							abort_run($sformatf("%s: output %0d sent an unknown packet",
								test_name, o));
						cur_src[o] = vec_in[int'(act.data[15:8])];
						if (rot_check && o == int'(PORT_L)) begin
							if (!rot_first) begin
								want = next_waiting(o, last_src[o]);
								assert (cur_src[o] == want) else
									flag_mismatch("input served on local",
										32'(want), 32'(cur_src[o]));
							end
							rot_first = 1'b0;
						end
						busy[o] = 1'b1;
					end
					src = cur_src[o];
					key = o * NUM_PORTS + src;
					assert (exp_q[key].size() != 0) else
						abort_run($sformatf(
							"%s: output %0d delivered a flit from input %0d %s",
							test_name, o, src, "that was not sent there"));
					expf = exp_q[key].pop_front();
					assert (act == expf) else
						flag_mismatch($sformatf("flit from input %0d on output %0d", src, o),
							32'(expf), 32'(act));
					occ[src]--;
					if (act.tail) begin
						busy[o]     = 1'b0;
						last_src[o] = src;
						delivered++;
					end
				end
			end
			for (int s = 0; s < NUM_PORTS; s++) begin
				if (in_valid[s] && in_ready[s]) begin
					if (in_flit[s].head)
						route_q[s] = route_of(in_flit[s].data[ADDR_W-1:0]);
					exp_q[int'(route_q[s]) * NUM_PORTS + s].push_back(in_flit[s]);
					occ[s]++;
				end
			end
		end
	end

	initial begin
		rst_n       = 1'b0;
		router_addr = ROUTER_ADDR;
		in_valid    = '0;
		jitter_on   = 1'b0;
		rot_check   = 1'b0;
		rot_first   = 1'b1;
		delivered   = 0;
		test_name   = "reset";
		for (int p = 0; p < NUM_PORTS; p++) begin
			in_flit[p]  = '0;
			route_q[p]  = PORT_N;
			occ[p]      = 0;
			busy[p]     = 1'b0;
			cur_src[p]  = 0;
			last_src[p] = 0;
		end
		load_vectors();
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;
		@(negedge clk);
		assert (out_valid == '0) else
			flag_mismatch("out_valid after reset", 32'd0, 32'(out_valid));
		assert (in_ready == '1) else
			flag_mismatch("in_ready after reset", 32'h1f, 32'(in_ready));

		for (int grp = 1; grp <= NUM_GROUPS; grp++) begin
			test_name = group_name(grp);
			jitter_on = (grp == JITTER_GROUP);
			rot_check = (grp == ROTATE_GROUP);
			rot_first = 1'b1;
			@(posedge clk);
			#1;
			fork
				send_port(0, grp);
				send_port(1, grp);
				send_port(2, grp);
				send_port(3, grp);
				send_port(4, grp);
			join
			drain_queues();
		end

		test_name = "summary";
		assert (delivered == num_pkts) else
			flag_mismatch("delivered packet count", 32'(num_pkts), 32'(delivered));
		$display("NO ERRORS");
		$finish;
	end

endmodule

//--- sim/router_vectors.txt
// columns: group, input port (0 N, 1 S, 2 W, 3 E, 4 L), destination YX, length, first payload
// router sits at YX 22, the line starting with ff ends the list
1 0 02 2 1000
1 1 52 3 1100
1 2 25 1 1200
1 3 21 2 1300
1 4 22 3 1400
2 0 2f 3 2000
2 1 20 2 2100
2 2 22 1 2200
2 3 95 3 2300
2 4 17 2 2400
3 0 24 4 3000
3 1 2a 3 3100
3 2 26 4 3200
3 4 2c 2 3300
3 0 27 2 3400
3 2 2e 3 3500
4 0 22 2 4000
4 1 22 3 4100
4 3 22 2 4200
4 0 22 3 4300
4 1 22 2 4400
4 3 22 3 4500
4 0 22 2 4600
4 1 22 2 4700
4 3 22 3 4800
4 0 22 3 4900
4 1 22 2 4a00
4 3 22 2 4b00
5 0 22 4 5000
5 1 22 3 5100
5 2 62 4 5200
5 3 02 2 5300
5 4 28 4 5400
5 0 2f 3 5500
5 1 21 4 5600
5 2 33 2 5700
5 3 11 3 5800
5 4 a0 4 5900
ff 0 00 0 0000

//--- vlog.f
src/noc_pkg.sv
src/flit_fifo.sv
src/route_unit.sv
src/rr_arbiter.sv
src/crossbar_switch.sv
src/router_core.sv
sim/tb_router_core.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_router_core
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= NO ERRORS

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard src/*.sv sim/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
